// ==== filelist.f ====
+incdir+hdl
hdl/cache_op_pkg.sv
hdl/prof_event_pkg.sv
hdl/vcache_event_decode.sv
hdl/stat_slice.sv
hdl/stat_dump_ctrl.sv
hdl/vcache_profiler_top.sv
verification/stat_checker.sv
verification/tb_vcache_profiler.sv

// ==== hdl/cache_op_pkg.sv ====
// cache-side types: access size, address, way index, way vector, byte mask
`include "prof_config.svh"

package cache_op_pkg;

  // access size as carried in the pipeline decode
  typedef enum logic [1:0] {
    e_size_byte   = 2'b00,
    e_size_half   = 2'b01,
    e_size_word   = 2'b10,
    e_size_double = 2'b11  // reserved for 64-bit
  } size_e;

  typedef logic [`PROF_ADDR_WIDTH-1:0] addr_t;

  typedef logic [$clog2(`PROF_WAYS)-1:0] way_idx_t;

  // one bit per way, valid or dirty
  typedef logic [`PROF_WAYS-1:0] way_vec_t;

  typedef logic [`PROF_WORD_BYTES-1:0] byte_mask_t;

endpackage

// ==== hdl/prof_config.svh ====
// profiler build constants: address width, ways, counter width,
// word size and number of counted events
`ifndef PROF_CONFIG_SVH
`define PROF_CONFIG_SVH

// cache address bits
`define PROF_ADDR_WIDTH 32

// ways per set
`define PROF_WAYS 8

// counters wrap modulo 2**PROF_CNT_WIDTH
`define PROF_CNT_WIDTH 32

// bytes per word, also the sequential address stride
`define PROF_WORD_BYTES 4

// one counter slice per event
`define PROF_NUM_EVENTS 23

`endif

// ==== hdl/prof_event_pkg.sv ====
// profiler-side types: event index, event vector, count and tag words
`include "prof_config.svh"

package prof_event_pkg;

  // order matches the dump stream order
  typedef enum logic [4:0] {
    e_ld              = 5'd0,
    e_ld_lw           = 5'd1,
    e_ld_lwu          = 5'd2,
    e_ld_lh           = 5'd3,
    e_ld_lhu          = 5'd4,
    e_ld_lb           = 5'd5,
    e_ld_lbu          = 5'd6,
    e_seq_ld          = 5'd7,
    e_st              = 5'd8,
    e_sm_sw           = 5'd9,
    e_sm_sh           = 5'd10,
    e_sm_sb           = 5'd11,
    e_seq_st          = 5'd12,
    e_miss_cycle      = 5'd13,  // miss handler busy, no response
    e_miss_ld         = 5'd14,
    e_miss_st         = 5'd15,
    e_stall_rsp       = 5'd16,  // response not taken
    e_idle            = 5'd17,
    e_dma_read        = 5'd18,
    e_dma_write       = 5'd19,
    e_replace_invalid = 5'd20,
    e_replace_valid   = 5'd21,
    e_replace_dirty   = 5'd22
  } event_e;

  // one strobe per event, indexed by event_e
  typedef logic [`PROF_NUM_EVENTS-1:0] event_vec_t;

  typedef logic [`PROF_CNT_WIDTH-1:0] count_t;

  typedef logic [31:0] tag_t;

endpackage

// ==== hdl/stat_dump_ctrl.sv ====
// dump sequencer: snapshots all counters on a print request and streams
// them out with index, last flag and tag
`timescale 1ns/1ns
`include "prof_config.svh"

module stat_dump_ctrl (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   print_stat_v_i,
  input  prof_event_pkg::tag_t   print_tag_i,
  input  prof_event_pkg::count_t head_i,
  output logic                   capture_o,
  output logic                   shift_o,
  output logic                   stat_v_o,
  output prof_event_pkg::event_e stat_idx_o,
  output prof_event_pkg::count_t stat_data_o,
  output logic                   stat_last_o,
  output prof_event_pkg::tag_t   stat_tag_o
);

  localparam prof_event_pkg::event_e first_idx_lp = prof_event_pkg::event_e'(0);
  localparam prof_event_pkg::event_e last_idx_lp =
    prof_event_pkg::event_e'(`PROF_NUM_EVENTS - 1);

  typedef enum logic {
    e_dump_idle,
    e_dump_busy
  } state_e;

  state_e                 state_r;
  prof_event_pkg::event_e idx_r;
  prof_event_pkg::tag_t   tag_r;
  logic                   at_last;

  // requests only count while idle
  assign capture_o = print_stat_v_i & (state_r == e_dump_idle);
  assign stat_v_o  = (state_r == e_dump_busy);
  assign shift_o   = stat_v_o;  // advance chain after each word
  assign at_last   = (idx_r == last_idx_lp);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_dump_idle;
      idx_r   <= first_idx_lp;
    end else begin
      case (state_r)
        e_dump_idle: begin
          if (capture_o) begin
            state_r <= e_dump_busy;
            idx_r   <= first_idx_lp;
          end
        end
        e_dump_busy: begin
          if (at_last) begin
            state_r <= e_dump_idle;
            idx_r   <= first_idx_lp;
          end else begin
            idx_r <= prof_event_pkg::event_e'(idx_r + 1'b1);
          end
        end
        default: state_r <= e_dump_idle;
      endcase
    end
  end

  // tag held for the whole stream
  always_ff @(posedge clk_i) begin
    if (capture_o) begin
      tag_r <= print_tag_i;
    end
  end

  assign stat_idx_o  = idx_r;
  assign stat_data_o = head_i;  // slice 0 shadow
  assign stat_last_o = stat_v_o & at_last;
  assign stat_tag_o  = tag_r;

endmodule

// ==== hdl/stat_slice.sv ====
// single event counter with its snapshot register, one stage of the
// dump shift chain
`timescale 1ns/1ns

module stat_slice (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   inc_i,
  input  logic                   capture_i,
  input  logic                   shift_i,
  input  prof_event_pkg::count_t next_i,    // shadow of the next slice up
  output prof_event_pkg::count_t shadow_o
);

  prof_event_pkg::count_t cnt_r;
  prof_event_pkg::count_t shadow_r;

  // live count, keeps running during a dump
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_r <= '0;
    end else if (inc_i) begin
      cnt_r <= cnt_r + prof_event_pkg::count_t'(1);  // wraps
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      shadow_r <= cnt_r;  // snapshot
    end else if (shift_i) begin
      shadow_r <= next_i;  // move toward slice 0
    end
  end

  assign shadow_o = shadow_r;

endmodule

// ==== hdl/vcache_event_decode.sv ====
// event decoder: classifies vcache pipeline strobes into a registered
// event vector, one strobe per counter
`timescale 1ns/1ns
`include "prof_config.svh"

module vcache_event_decode (
  input  logic                       clk_i,
  input  logic                       reset_i,
  // output stage
  input  logic                       v_i,
  input  logic                       yumi_i,
  input  logic                       miss_i,
  input  logic                       ld_v_i,
  input  logic                       st_v_i,
  input  cache_op_pkg::size_e        size_v_i,
  input  logic                       sigext_v_i,
  input  cache_op_pkg::byte_mask_t   mask_v_i,
  input  cache_op_pkg::addr_t        addr_v_i,
  // tag-lookup stage
  input  logic                       ld_tl_i,
  input  logic                       st_tl_i,
  input  cache_op_pkg::size_e        size_tl_i,
  input  cache_op_pkg::byte_mask_t   mask_tl_i,
  input  cache_op_pkg::addr_t        addr_tl_i,
  // dma
  input  logic                       dma_pkt_v_i,
  input  logic                       dma_pkt_yumi_i,
  input  logic                       dma_write_i,
  // replacement
  input  logic                       fill_done_i,
  input  cache_op_pkg::way_idx_t     chosen_way_i,
  input  cache_op_pkg::way_vec_t     valid_v_i,
  input  cache_op_pkg::way_vec_t     dirty_i,
  output prof_event_pkg::event_vec_t event_o
);

  prof_event_pkg::event_vec_t event_n;
  prof_event_pkg::event_vec_t event_r;

  logic       accept;
  logic       acc_ld;
  logic       acc_st;
  logic [2:0] pop_v;
  logic [2:0] pop_tl;
  logic       seq_addr;
  logic       word_ld_both;
  logic       full_st_both;
  logic       dma_fire;
  logic       victim_valid;
  logic       victim_dirty;

  assign accept = v_i & yumi_i;  // response leaves the cache
  assign acc_ld = accept & ld_v_i;
  assign acc_st = accept & st_v_i;

  assign pop_v  = 3'($countones(mask_v_i));
  assign pop_tl = 3'($countones(mask_tl_i));

  // next access is the following word
  assign seq_addr = cache_op_pkg::addr_t'(addr_v_i + `PROF_WORD_BYTES) == addr_tl_i;

  assign word_ld_both = ld_v_i & (size_v_i == cache_op_pkg::e_size_word)
                      & ld_tl_i & (size_tl_i == cache_op_pkg::e_size_word);
  assign full_st_both = st_v_i & (pop_v == 3'd4)
                      & st_tl_i & (pop_tl == 3'd4);

  assign dma_fire = dma_pkt_v_i & dma_pkt_yumi_i;

  // state of the way being filled
  assign victim_valid = valid_v_i[chosen_way_i];
  assign victim_dirty = dirty_i[chosen_way_i];

  always_comb begin
    event_n = '0;

    // loads, split by size and sign extension
    event_n[prof_event_pkg::e_ld]     = acc_ld;
    event_n[prof_event_pkg::e_ld_lw]  = acc_ld & (size_v_i == cache_op_pkg::e_size_word) & sigext_v_i;
    event_n[prof_event_pkg::e_ld_lwu] = acc_ld & (size_v_i == cache_op_pkg::e_size_word) & ~sigext_v_i;
    event_n[prof_event_pkg::e_ld_lh]  = acc_ld & (size_v_i == cache_op_pkg::e_size_half) & sigext_v_i;
    event_n[prof_event_pkg::e_ld_lhu] = acc_ld & (size_v_i == cache_op_pkg::e_size_half) & ~sigext_v_i;
    event_n[prof_event_pkg::e_ld_lb]  = acc_ld & (size_v_i == cache_op_pkg::e_size_byte) & sigext_v_i;
    event_n[prof_event_pkg::e_ld_lbu] = acc_ld & (size_v_i == cache_op_pkg::e_size_byte) & ~sigext_v_i;
    event_n[prof_event_pkg::e_seq_ld] = acc_ld & seq_addr & word_ld_both;

    // stores by mask popcount only
    event_n[prof_event_pkg::e_st]     = acc_st;
    event_n[prof_event_pkg::e_sm_sw]  = acc_st & (pop_v == 3'd4);
    event_n[prof_event_pkg::e_sm_sh]  = acc_st & (pop_v == 3'd2);
    event_n[prof_event_pkg::e_sm_sb]  = acc_st & (pop_v == 3'd1);
    event_n[prof_event_pkg::e_seq_st] = acc_st & seq_addr & full_st_both;

    event_n[prof_event_pkg::e_miss_cycle] = miss_i & ~v_i;
    event_n[prof_event_pkg::e_miss_ld]    = acc_ld & miss_i;
    event_n[prof_event_pkg::e_miss_st]    = acc_st & miss_i;
    event_n[prof_event_pkg::e_stall_rsp]  = v_i & ~yumi_i;
    event_n[prof_event_pkg::e_idle]       = ~v_i & ~miss_i;

    event_n[prof_event_pkg::e_dma_read]  = dma_fire & ~dma_write_i;
    event_n[prof_event_pkg::e_dma_write] = dma_fire & dma_write_i;

    // victim classification on fill completion
    event_n[prof_event_pkg::e_replace_invalid] = fill_done_i & ~victim_valid;
    event_n[prof_event_pkg::e_replace_valid]   = fill_done_i & victim_valid & ~victim_dirty;
    event_n[prof_event_pkg::e_replace_dirty]   = fill_done_i & victim_valid & victim_dirty;
  end

  // one register stage keeps all slices aligned
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      event_r <= '0;
    end else begin
      event_r <= event_n;
    end
  end

  assign event_o = event_r;

endmodule

// ==== hdl/vcache_profiler_top.sv ====
// vcache profiler top: event decoder, one counter slice per event,
// and the dump sequencer draining the slice chain
`timescale 1ns/1ns
`include "prof_config.svh"

module vcache_profiler_top (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     v_i,
  input  logic                     yumi_i,
  input  logic                     miss_i,
  input  logic                     ld_v_i,
  input  logic                     st_v_i,
  input  cache_op_pkg::size_e      size_v_i,
  input  logic                     sigext_v_i,
  input  cache_op_pkg::byte_mask_t mask_v_i,
  input  cache_op_pkg::addr_t      addr_v_i,
  input  logic                     ld_tl_i,
  input  logic                     st_tl_i,
  input  cache_op_pkg::size_e      size_tl_i,
  input  cache_op_pkg::byte_mask_t mask_tl_i,
  input  cache_op_pkg::addr_t      addr_tl_i,
  input  logic                     dma_pkt_v_i,
  input  logic                     dma_pkt_yumi_i,
  input  logic                     dma_write_i,
  input  logic                     fill_done_i,
  input  cache_op_pkg::way_idx_t   chosen_way_i,
  input  cache_op_pkg::way_vec_t   valid_v_i,
  input  cache_op_pkg::way_vec_t   dirty_i,
  input  logic                     print_stat_v_i,
  input  prof_event_pkg::tag_t     print_tag_i,
  output logic                     stat_v_o,
  output prof_event_pkg::event_e   stat_idx_o,
  output prof_event_pkg::count_t   stat_data_o,
  output logic                     stat_last_o,
  output prof_event_pkg::tag_t     stat_tag_o
);

  prof_event_pkg::event_vec_t event_r;
  logic                       capture;
  logic                       shift;
  // chain[i] is slice i shadow, top entry feeds zeros in
  prof_event_pkg::count_t     chain [`PROF_NUM_EVENTS+1];

  vcache_event_decode i_decode (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .v_i            (v_i),
    .yumi_i         (yumi_i),
    .miss_i         (miss_i),
    .ld_v_i         (ld_v_i),
    .st_v_i         (st_v_i),
    .size_v_i       (size_v_i),
    .sigext_v_i     (sigext_v_i),
    .mask_v_i       (mask_v_i),
    .addr_v_i       (addr_v_i),
    .ld_tl_i        (ld_tl_i),
    .st_tl_i        (st_tl_i),
    .size_tl_i      (size_tl_i),
    .mask_tl_i      (mask_tl_i),
    .addr_tl_i      (addr_tl_i),
    .dma_pkt_v_i    (dma_pkt_v_i),
    .dma_pkt_yumi_i (dma_pkt_yumi_i),
    .dma_write_i    (dma_write_i),
    .fill_done_i    (fill_done_i),
    .chosen_way_i   (chosen_way_i),
    .valid_v_i      (valid_v_i),
    .dirty_i        (dirty_i),
    .event_o        (event_r)
  );

  assign chain[`PROF_NUM_EVENTS] = '0;

  for (genvar i = 0; i < `PROF_NUM_EVENTS; i++) begin : g_slice
    stat_slice i_slice (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .inc_i     (event_r[i]),
      .capture_i (capture),
      .shift_i   (shift),
      .next_i    (chain[i+1]),
      .shadow_o  (chain[i])
    );
  end

  stat_dump_ctrl i_dump (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .print_stat_v_i (print_stat_v_i),
    .print_tag_i    (print_tag_i),
    .head_i         (chain[0]),
    .capture_o      (capture),
    .shift_o        (shift),
    .stat_v_o       (stat_v_o),
    .stat_idx_o     (stat_idx_o),
    .stat_data_o    (stat_data_o),
    .stat_last_o    (stat_last_o),
    .stat_tag_o     (stat_tag_o)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the profiler testbench with Verilator
verilator --binary --timing --top-module tb_vcache_profiler -f filelist.f -o sim_tb \
  > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat build.log; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0

// ==== verification/stat_checker.sv ====
// profiler checker: reference event function, shadow counters and
// comparison of every streamed dump word
`timescale 1ns/1ns
`include "prof_config.svh"

module stat_checker (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       v_i, yumi_i, miss_i, ld_v_i, st_v_i, sigext_v_i,
  input  cache_op_pkg::size_e        size_v_i, size_tl_i,
  input  cache_op_pkg::byte_mask_t   mask_v_i, mask_tl_i,
  input  cache_op_pkg::addr_t        addr_v_i, addr_tl_i,
  input  logic                       ld_tl_i, st_tl_i,
  input  logic                       dma_pkt_v_i, dma_pkt_yumi_i, dma_write_i,
  input  logic                       fill_done_i,
  input  cache_op_pkg::way_idx_t     chosen_way_i,
  input  cache_op_pkg::way_vec_t     valid_v_i, dirty_i,
  input  logic                       print_stat_v_i,
  input  prof_event_pkg::tag_t       print_tag_i,
  input  logic                       stat_v_o, stat_last_o,
  input  prof_event_pkg::event_e     stat_idx_o,
  input  prof_event_pkg::count_t     stat_data_o,
  input  prof_event_pkg::tag_t       stat_tag_o,
  output int                         error_count_o,
  output int                         stream_count_o
);

  prof_event_pkg::count_t     cnt  [`PROF_NUM_EVENTS];
  prof_event_pkg::count_t     snap [`PROF_NUM_EVENTS];  // counts frozen at the request
  prof_event_pkg::tag_t       snap_tag;
  prof_event_pkg::event_vec_t ev_pipe;                  // decoder register stage
  logic                       busy;
  logic                       accept;
  int                         word_n;
  int                         errors = 0;
  int                         streams = 0;

  assign error_count_o  = errors;
  assign stream_count_o = streams;

  // expected events for the inputs of the current cycle
  function automatic prof_event_pkg::event_vec_t classify_cycle();
    prof_event_pkg::event_vec_t ev;
    prof_event_pkg::event_e     ld_evt;
    logic                       ld_acc;
    logic                       st_acc;
    logic                       seq;
    int                         pop_v;
    int                         pop_tl;
    ev     = '0;
    ld_acc = v_i && yumi_i && ld_v_i;
    st_acc = v_i && yumi_i && st_v_i;
    pop_v  = 32'(mask_v_i[0]) + 32'(mask_v_i[1]) + 32'(mask_v_i[2]) + 32'(mask_v_i[3]);
    pop_tl = 32'(mask_tl_i[0]) + 32'(mask_tl_i[1]) + 32'(mask_tl_i[2]) + 32'(mask_tl_i[3]);
    seq    = cache_op_pkg::addr_t'(addr_tl_i - addr_v_i)
             == cache_op_pkg::addr_t'(`PROF_WORD_BYTES);
    if (ld_acc) begin
      ld_evt = prof_event_pkg::e_ld;
      case (size_v_i)
        cache_op_pkg::e_size_word:
          ld_evt = sigext_v_i ? prof_event_pkg::e_ld_lw : prof_event_pkg::e_ld_lwu;
        cache_op_pkg::e_size_half:
          ld_evt = sigext_v_i ? prof_event_pkg::e_ld_lh : prof_event_pkg::e_ld_lhu;
        cache_op_pkg::e_size_byte:
          ld_evt = sigext_v_i ? prof_event_pkg::e_ld_lb : prof_event_pkg::e_ld_lbu;
        default: ld_evt = prof_event_pkg::e_ld;  // double has no size event
      endcase
      ev[prof_event_pkg::e_ld] = 1'b1;
      ev[ld_evt] = 1'b1;
      ev[prof_event_pkg::e_seq_ld] = seq && size_v_i == cache_op_pkg::e_size_word
                                     && ld_tl_i && size_tl_i == cache_op_pkg::e_size_word;
    end
    if (st_acc) begin
      ev[prof_event_pkg::e_st]     = 1'b1;
      ev[prof_event_pkg::e_sm_sw]  = pop_v == 4;
      ev[prof_event_pkg::e_sm_sh]  = pop_v == 2;
      ev[prof_event_pkg::e_sm_sb]  = pop_v == 1;
      ev[prof_event_pkg::e_seq_st] = seq && pop_v == 4 && st_tl_i && pop_tl == 4;
    end
    ev[prof_event_pkg::e_miss_cycle] = miss_i && !v_i;
    ev[prof_event_pkg::e_miss_ld]    = ld_acc && miss_i;
    ev[prof_event_pkg::e_miss_st]    = st_acc && miss_i;
    ev[prof_event_pkg::e_stall_rsp]  = v_i && !yumi_i;
    ev[prof_event_pkg::e_idle]       = !v_i && !miss_i;
    ev[prof_event_pkg::e_dma_read]   = dma_pkt_v_i && dma_pkt_yumi_i && !dma_write_i;
    ev[prof_event_pkg::e_dma_write]  = dma_pkt_v_i && dma_pkt_yumi_i && dma_write_i;
    if (fill_done_i) begin
      if (!valid_v_i[chosen_way_i]) ev[prof_event_pkg::e_replace_invalid] = 1'b1;
      else if (dirty_i[chosen_way_i]) ev[prof_event_pkg::e_replace_dirty] = 1'b1;
      else ev[prof_event_pkg::e_replace_valid] = 1'b1;
    end
    return ev;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s expected 0x%08h got 0x%08h at %0t", name, expected, actual, $time);
    end
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      ev_pipe = '0;
      busy    = 1'b0;
      word_n  = 0;
      for (int e = 0; e < `PROF_NUM_EVENTS; e++) cnt[e] = '0;
    end else begin
      accept = print_stat_v_i && !busy;  // requests during a stream are dropped
      if (busy) begin
        if (stat_v_o !== 1'b1) begin
          errors++;
          $display("stream word %0d missing, valid is low at %0t", word_n, $time);
        end else begin
          check_value("stat_idx_o", 32'(word_n), 32'(stat_idx_o));
          check_value("stat_data_o", snap[word_n], stat_data_o);
          check_value("stat_last_o", 32'(word_n == `PROF_NUM_EVENTS - 1), 32'(stat_last_o));
          check_value("stat_tag_o", snap_tag, stat_tag_o);
        end
        word_n++;
        if (word_n == `PROF_NUM_EVENTS) busy = 1'b0;
      end else if (stat_v_o !== 1'b0 || stat_last_o !== 1'b0) begin
        errors++;
        $display("stream active with no dump pending at %0t", $time);
      end
      // every stream the DUT finishes, wanted or stray
      if (stat_v_o === 1'b1 && stat_last_o === 1'b1) streams++;
      if (accept) begin
        snap     = cnt;
        snap_tag = print_tag_i;
        busy     = 1'b1;
        word_n   = 0;
      end
      // events seen one edge ago land in the counters now
      for (int e = 0; e < `PROF_NUM_EVENTS; e++) begin
        if (ev_pipe[e]) cnt[e] = cnt[e] + prof_event_pkg::count_t'(1);
      end
      ev_pipe = classify_cycle();
    end
  end

endmodule

// ==== verification/tb_vcache_profiler.sv ====
// profiler testbench: clock, reset, seeded random pipeline traffic
// and dump requests
`timescale 1ns/1ns
`include "prof_config.svh"

module tb_vcache_profiler;

  logic                     clk_i;
  logic                     reset_i;
  logic                     v_i, yumi_i, miss_i, ld_v_i, st_v_i, sigext_v_i;
  cache_op_pkg::size_e      size_v_i, size_tl_i;
  cache_op_pkg::byte_mask_t mask_v_i, mask_tl_i;
  cache_op_pkg::addr_t      addr_v_i, addr_tl_i;
  logic                     ld_tl_i, st_tl_i;
  logic                     dma_pkt_v_i, dma_pkt_yumi_i, dma_write_i, fill_done_i;
  cache_op_pkg::way_idx_t   chosen_way_i;
  cache_op_pkg::way_vec_t   valid_v_i, dirty_i;
  logic                     print_stat_v_i;
  prof_event_pkg::tag_t     print_tag_i;
  logic                     stat_v_o, stat_last_o;
  prof_event_pkg::event_e   stat_idx_o;
  prof_event_pkg::count_t   stat_data_o;
  prof_event_pkg::tag_t     stat_tag_o;
  int                       chk_errors;
  int                       stream_count;
  int                       tb_errors = 0;

  vcache_profiler_top i_dut (.*);

  stat_checker i_checker (.*, .error_count_o(chk_errors), .stream_count_o(stream_count));

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic coin();
    return $urandom_range(0, 1) == 1;
  endfunction

  // full, half and single byte masks, plus the odd random one
  function automatic cache_op_pkg::byte_mask_t pick_mask();
    case ($urandom_range(0, 5))
      0, 1:    return 4'hf;
      2:       return 4'h3;
      3:       return 4'hc;
      4:       return 4'h1;
      default: return cache_op_pkg::byte_mask_t'($urandom);
    endcase
  endfunction

  task automatic quiet_inputs();
    {v_i, yumi_i, miss_i, ld_v_i, st_v_i, sigext_v_i, ld_tl_i, st_tl_i} = '0;
    {dma_pkt_v_i, dma_pkt_yumi_i, dma_write_i, fill_done_i} = '0;
    size_v_i  = cache_op_pkg::e_size_byte;
    size_tl_i = cache_op_pkg::e_size_byte;
    {mask_v_i, mask_tl_i, addr_v_i, addr_tl_i} = '0;
    {chosen_way_i, valid_v_i, dirty_i} = '0;
  endtask

  // mode 0 loads, 1 stores, 2 miss and stall mix, 3 dma and fills
  task automatic drive_cycle(input int mode);
    @(negedge clk_i);
    quiet_inputs();
    v_i            = (mode == 2) ? coin() : ($urandom_range(0, 3) != 0);
    yumi_i         = (mode == 2) ? coin() : (v_i && $urandom_range(0, 3) != 0);
    miss_i         = (mode == 2) && coin();
    ld_v_i         = (mode == 0) || ((mode == 2) && coin());
    st_v_i         = (mode == 1) || ((mode == 2) && !ld_v_i);
    size_v_i       = cache_op_pkg::size_e'(2'($urandom_range(0, 2)));
    sigext_v_i     = coin();
    mask_v_i       = pick_mask();
    addr_v_i       = cache_op_pkg::addr_t'($urandom) & ~cache_op_pkg::addr_t'(3);
    addr_tl_i      = coin() ? addr_v_i + cache_op_pkg::addr_t'(4)
                            : cache_op_pkg::addr_t'($urandom);
    ld_tl_i        = ld_v_i && $urandom_range(0, 3) != 0;
    st_tl_i        = st_v_i && $urandom_range(0, 3) != 0;
    size_tl_i      = coin() ? cache_op_pkg::e_size_word : size_v_i;
    mask_tl_i      = coin() ? 4'hf : pick_mask();
    dma_pkt_v_i    = (mode == 3) && coin();
    dma_pkt_yumi_i = coin();
    dma_write_i    = coin();
    fill_done_i    = (mode == 3) && coin();
    chosen_way_i   = cache_op_pkg::way_idx_t'($urandom_range(0, `PROF_WAYS - 1));
    valid_v_i      = cache_op_pkg::way_vec_t'($urandom);
    dirty_i        = cache_op_pkg::way_vec_t'($urandom);
  endtask

  task automatic wait_streams(input int target);
    int cycles;
    cycles = 0;
    while (stream_count < target && cycles < 100) begin
      @(negedge clk_i);
      cycles++;
    end
    if (stream_count < target) begin
      tb_errors++;
      $display("timeout: dump stream %0d did not finish within 100 cycles", target);
    end
  endtask

  // one request, optionally a second one in the middle of the stream
  task automatic request_dump(input prof_event_pkg::tag_t tag, input logic again);
    int expected;
    expected = stream_count + 1;
    @(negedge clk_i);
    print_stat_v_i = 1'b1;
    print_tag_i    = tag;
    @(negedge clk_i);
    print_stat_v_i = 1'b0;
    if (again) begin
      repeat (6) @(negedge clk_i);
      print_stat_v_i = 1'b1;
      print_tag_i    = ~tag;
      @(negedge clk_i);
      print_stat_v_i = 1'b0;
    end
    wait_streams(expected);
    repeat (30) @(negedge clk_i);  // a stray stream would show up here
    if (stream_count != expected) begin
      tb_errors++;
      $display("expected %0d dump streams but saw %0d", expected, stream_count);
    end
  endtask

  initial begin
    void'($urandom(83));
    quiet_inputs();
    print_stat_v_i = 1'b0;
    print_tag_i    = '0;
    reset_i        = 1'b1;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    repeat (10) @(negedge clk_i);
    request_dump(32'hcafe_0001, 1'b0);  // only idle counts so far
    for (int mode = 0; mode < 4; mode++) begin
      repeat (200) drive_cycle(mode);
      @(negedge clk_i);
      quiet_inputs();
      request_dump(prof_event_pkg::tag_t'($urandom), 1'b0);
    end
    repeat (300) drive_cycle(int'($urandom_range(0, 3)));
    @(negedge clk_i);
    quiet_inputs();
    request_dump(prof_event_pkg::tag_t'($urandom), 1'b1);
    $display("run complete: %0d checker errors, %0d testbench errors", chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
